// File: dv/duck_hunt_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "duck_defs.svh"

module duck_hunt_tb
    import duck_pkg::*;
();

    typedef enum logic [2:0] {
        act_idle,
        act_enable,
        act_fire_miss,
        act_fire_duck,
        act_reload
    } action_t;

    // the part of status that each row checks
    typedef struct packed {
        logic [2:0] mag;
        logic [6:0] res;
        logic [6:0] score;
        logic       reload_char;
        logic       hunt;
    } view_t;

    typedef struct packed {
        action_t     act;
        logic [15:0] wait_cyc;
        view_t       expect_view;
    } row_t;

    logic         clk;
    logic         rst;
    duck_pos_t    mouse_pos;
    logic         left_mouse;
    logic         right_mouse;
    logic         game_enable;
    game_status_t status;
    duck_pos_t    duck;

    row_t  rows[$];
    string names[$];
    int    pass_count = 0;
    int    fail_count = 0;
    int    cycle_count = 0;
    int    timeout_limit = 0;
    int    kill_count = 0;

    duck_hunt_top duck_hunt_top_inst (
        .clk         (clk),
        .rst         (rst),
        .mouse_pos   (mouse_pos),
        .left_mouse  (left_mouse),
        .right_mouse (right_mouse),
        .game_enable (game_enable),
        .status      (status),
        .duck        (duck)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // one count per cycle that duck_killed is high
    always @(posedge clk) begin : kill_monitor
        if (!rst && status.duck_killed === 1'b1) begin
            kill_count = kill_count + 1;
        end
    end

    // --------------------
    // helpers
    // --------------------
    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic add_row(input string name, input action_t act, input int wait_cyc,
                           input int mag, input int res, input int score,
                           input bit reload_char, input bit hunt);
        row_t row;
        row.act                     = act;
        row.wait_cyc                = wait_cyc;
        row.expect_view.mag         = mag;
        row.expect_view.res         = res;
        row.expect_view.score       = score;
        row.expect_view.reload_char = reload_char;
        row.expect_view.hunt        = hunt;
        rows.push_back(row);
        names.push_back(name);
    endtask

    function automatic string view_text(input view_t v);
        return $sformatf("mag=%0d res=%0d score=%0d reload_char=%0d hunt=%0d",
                         v.mag, v.res, v.score, v.reload_char, v.hunt);
    endfunction

    // two-cycle button press, then release
    task automatic press_button(input bit use_right, input duck_pos_t pos);
        mouse_pos = pos;
        if (use_right) begin
            right_mouse = 1'b1;
        end else begin
            left_mouse = 1'b1;
        end
        next_cycle();
        next_cycle();
        left_mouse  = 1'b0;
        right_mouse = 1'b0;
    endtask

    task automatic apply_row(input int idx);
        duck_pos_t   aim;
        view_t       actual;
        game_state_t exp_state;
        bit          ok;
        ok = 1'b1;
        case (rows[idx].act)
            act_enable: game_enable = 1'b1;
            act_fire_miss: begin
                aim = '0;
                press_button(1'b0, aim);
            end
            act_fire_duck: begin
                // centre of the hit box as it stands now
                aim.xpos = duck.xpos + `DUCK_WIDTH / 2;
                aim.ypos = duck.ypos + `DUCK_HEIGHT / 2;
                press_button(1'b0, aim);
            end
            act_reload: press_button(1'b1, mouse_pos);
            default: ;
        endcase
        repeat (rows[idx].wait_cyc) next_cycle();

        actual.mag         = status.bullets_in_magazine;
        actual.res         = status.bullets_left;
        actual.score       = status.score;
        actual.reload_char = status.show_reload_char;
        actual.hunt        = status.hunt_start;
        if (actual !== rows[idx].expect_view) begin
            ok = 1'b0;
            $display("FAILED %s expected %s actual %s", names[idx],
                     view_text(rows[idx].expect_view), view_text(actual));
        end

        // off, paused or in play
        if (rows[idx].expect_view.hunt) begin
            exp_state = hunting;
        end else if (game_enable) begin
            exp_state = delay;
        end else begin
            exp_state = wait_for_start;
        end
        if (status.state !== exp_state) begin
            ok = 1'b0;
            $display("FAILED %s state expected %0d actual %0d", names[idx],
                     exp_state, status.state);
        end

        // each point comes from exactly one single-cycle kill pulse
        if (kill_count != rows[idx].expect_view.score) begin
            ok = 1'b0;
            $display("FAILED %s duck_killed pulses expected %0d actual %0d", names[idx],
                     rows[idx].expect_view.score, kill_count);
        end

        // duck sits at its restart point during the death pause
        if (rows[idx].act == act_fire_duck && !rows[idx].expect_view.hunt) begin
            if (duck.xpos !== `COORD_W'(`DUCK_START_X) ||
                duck.ypos !== `COORD_W'(`DUCK_START_Y)) begin
                ok = 1'b0;
                $display("FAILED %s duck expected (%0d,%0d) actual (%0d,%0d)", names[idx],
                         `DUCK_START_X, `DUCK_START_Y, duck.xpos, duck.ypos);
            end
        end
        if (ok) begin
            pass_count = pass_count + 1;
            $display("ok     %s", names[idx]);
        end else begin
            fail_count = fail_count + 1;
        end
    endtask

    // --------------------
    // stimulus table
    // --------------------
    task automatic build_table();
        int res;
        int moved;
        int round;
        int shot;
        add_row("reset_state", act_idle, 4, 3, 27, 0, 0, 0);
        add_row("shot_while_off", act_fire_miss, 6, 3, 27, 0, 0, 0);
        add_row("enable", act_enable, 4, 3, 27, 0, 0, 0);
        add_row("shot_in_countdown", act_fire_miss, 6, 3, 27, 0, 0, 0);
        add_row("countdown_done", act_idle, `COUNTDOWN_CYCLES, 3, 27, 0, 0, 1);
        add_row("miss_one", act_fire_miss, 6, 2, 27, 0, 0, 1);
        add_row("hit_duck", act_fire_duck, 6, 1, 27, 1, 0, 0);
        add_row("death_pause_done", act_idle, `DEATH_CYCLES + 5, 1, 27, 1, 0, 1);
        add_row("spend_last", act_fire_miss, 6, 0, 27, 1, 0, 1);
        add_row("empty_click", act_fire_miss, 6, 0, 27, 1, 1, 1);
        add_row("reload_full", act_reload, 6, 3, 24, 1, 0, 1);
        add_row("spend_one", act_fire_miss, 6, 2, 24, 1, 0, 1);
        add_row("reload_one", act_reload, 6, 3, 23, 1, 0, 1);

        // empty the magazine and refill until the reserve runs short
        res = 23;
        for (round = 0; round < 8; round++) begin
            for (shot = 1; shot <= `MAG_SIZE; shot++) begin
                add_row($sformatf("spend_r%0d_s%0d", round, shot), act_fire_miss, 6,
                        `MAG_SIZE - shot, res, 1, 0, 1);
            end
            moved = (res < `MAG_SIZE) ? res : `MAG_SIZE;
            res   = res - moved;
            add_row($sformatf("reload_r%0d", round), act_reload, 6, moved, res, 1, 0, 1);
        end
        add_row("reload_dry", act_reload, 6, 2, 0, 1, 0, 1);
    endtask

    // --------------------
    // watchdog
    // --------------------
    initial begin : watchdog
        wait (timeout_limit > 0);
        while (cycle_count < timeout_limit) begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("run timed out after %0d cycles before the table finished", cycle_count);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : main_run
        int i;
        int total_wait;
        rst         = 1'b1;
        mouse_pos   = '0;
        left_mouse  = 1'b0;
        right_mouse = 1'b0;
        game_enable = 1'b0;

        build_table();
        total_wait = 0;
        for (i = 0; i < rows.size(); i++) begin
            total_wait = total_wait + rows[i].wait_cyc;
        end
        timeout_limit = total_wait + `COUNTDOWN_CYCLES + 200;

        repeat (16) @(posedge clk);
        #2;
        rst = 1'b0;
        next_cycle();

        for (i = 0; i < rows.size(); i++) begin
            apply_row(i);
        end

        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: flist.f
+incdir+logic
logic/duck_pkg.sv
logic/shot_capture.sv
logic/shot_fifo.sv
logic/duck_flight.sv
logic/duck_game_logic.sv
logic/duck_hunt_top.sv
dv/duck_hunt_tb.sv

// File: logic/duck_defs.svh
`ifndef DUCK_DEFS_SVH
`define DUCK_DEFS_SVH

// --------------------
// screen geometry
// --------------------
`define COORD_W          12

// duck hit box in pixels
`define DUCK_WIDTH       96
`define DUCK_HEIGHT      60

// range of the duck's top-left corner
`define FLIGHT_X_MIN     32
`define FLIGHT_X_MAX     900
`define FLIGHT_Y_MIN     120
`define FLIGHT_Y_MAX     600

// restart point after reset and after a kill
`define DUCK_START_X     200
`define DUCK_START_Y     400

// --------------------
// timing in clock cycles
// --------------------
// sim-sized values, scale up for a real pixel clock
`define FLIGHT_STEP_CYCLES 8
`define COUNTDOWN_CYCLES   40
`define DEATH_CYCLES       20

// --------------------
// ammunition and event queue
// --------------------
`define MAG_SIZE         3
`define RESERVE_START    27
`define SHOT_FIFO_DEPTH  4

`endif

// File: logic/duck_flight.sv
`timescale 1ns/1ps
`default_nettype none

`include "duck_defs.svh"

module duck_flight
    import duck_pkg::*;
(
    input  wire       clk,
    input  wire       rst,
    input  wire       hunt_start,
    input  wire       duck_killed,
    output duck_pos_t duck
);

    localparam int step_w = (`FLIGHT_STEP_CYCLES > 1) ? $clog2(`FLIGHT_STEP_CYCLES) : 1;
    localparam logic [step_w-1:0] step_last = step_w'(`FLIGHT_STEP_CYCLES - 1);

    localparam logic [`COORD_W-1:0] x_min   = `FLIGHT_X_MIN;
    localparam logic [`COORD_W-1:0] x_max   = `FLIGHT_X_MAX;
    localparam logic [`COORD_W-1:0] y_min   = `FLIGHT_Y_MIN;
    localparam logic [`COORD_W-1:0] y_max   = `FLIGHT_Y_MAX;
    localparam logic [`COORD_W-1:0] start_x = `DUCK_START_X;
    localparam logic [`COORD_W-1:0] start_y = `DUCK_START_Y;

    logic [step_w-1:0] step_cnt;
    logic              step_tick;
    // heading, right and down after every restart
    logic              dir_right;
    logic              dir_down;

    assign step_tick = (step_cnt == step_last);

    always_ff @(posedge clk) begin
        if (rst) begin
            step_cnt  <= '0;
            dir_right <= 1'b1;
            dir_down  <= 1'b1;
            duck.xpos <= start_x;
            duck.ypos <= start_y;
        end else if (duck_killed) begin
            step_cnt  <= '0;
            dir_right <= 1'b1;
            dir_down  <= 1'b1;
            duck.xpos <= start_x;
            duck.ypos <= start_y;
        end else if (hunt_start) begin
            step_cnt <= step_tick ? '0 : step_cnt + 1'b1;

            if (step_tick) begin
                // horizontal bounce
                if (dir_right) begin
                    if (duck.xpos >= x_max) begin
                        dir_right <= 1'b0;
                        duck.xpos <= duck.xpos - 1'b1;
                    end else begin
                        duck.xpos <= duck.xpos + 1'b1;
                    end
                end else begin
                    if (duck.xpos <= x_min) begin
                        dir_right <= 1'b1;
                        duck.xpos <= duck.xpos + 1'b1;
                    end else begin
                        duck.xpos <= duck.xpos - 1'b1;
                    end
                end

                // vertical bounce
                if (dir_down) begin
                    if (duck.ypos >= y_max) begin
                        dir_down  <= 1'b0;
                        duck.ypos <= duck.ypos - 1'b1;
                    end else begin
                        duck.ypos <= duck.ypos + 1'b1;
                    end
                end else begin
                    if (duck.ypos <= y_min) begin
                        dir_down  <= 1'b1;
                        duck.ypos <= duck.ypos + 1'b1;
                    end else begin
                        duck.ypos <= duck.ypos - 1'b1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/duck_game_logic.sv
`timescale 1ns/1ps
`default_nettype none

`include "duck_defs.svh"

module duck_game_logic
    import duck_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire          game_enable,
    input  wire shot_event_t head,
    input  wire          empty,
    output logic         pop,
    input  wire duck_pos_t duck,
    output game_status_t status
);

    // --------------------
    // constants
    // --------------------
    localparam int delay_max = (`COUNTDOWN_CYCLES > `DEATH_CYCLES) ?
                               `COUNTDOWN_CYCLES : `DEATH_CYCLES;
    localparam int delay_w   = $clog2(delay_max + 1);

    localparam logic [delay_w-1:0] countdown_load = delay_w'(`COUNTDOWN_CYCLES - 1);
    localparam logic [delay_w-1:0] death_load     = delay_w'(`DEATH_CYCLES - 1);

    localparam logic [6:0] mag_full = `MAG_SIZE;
    localparam logic [`COORD_W:0] duck_w = `DUCK_WIDTH;
    localparam logic [`COORD_W:0] duck_h = `DUCK_HEIGHT;

    localparam game_status_t status_init = '{
        bullets_in_magazine: 3'(`MAG_SIZE),
        bullets_left:        7'(`RESERVE_START),
        score:               7'd0,
        hunt_start:          1'b0,
        show_reload_char:    1'b0,
        duck_killed:         1'b0,
        state:               wait_for_start
    };

    game_status_t       status_nxt;
    logic [delay_w-1:0] delay_cnt;
    logic [delay_w-1:0] delay_nxt;

    logic               take_shot;
    logic               take_reload;
    logic               hit;
    logic [`COORD_W:0]  duck_x_end;
    logic [`COORD_W:0]  duck_y_end;
    logic [6:0]         missing;
    logic [6:0]         moved;

    // --------------------
    // event intake
    // --------------------
    // queue is drained every cycle, unused events just fall away
    assign pop         = !empty;
    assign take_shot   = !empty && !head.is_reload;
    assign take_reload = !empty && head.is_reload;

    // hit box, edges count as a hit
    assign duck_x_end = {1'b0, duck.xpos} + duck_w;
    assign duck_y_end = {1'b0, duck.ypos} + duck_h;
    assign hit = (head.xpos >= duck.xpos) && ({1'b0, head.xpos} <= duck_x_end) &&
                 (head.ypos >= duck.ypos) && ({1'b0, head.ypos} <= duck_y_end);

    // refill limited by what is left in reserve
    assign missing = mag_full - {4'd0, status.bullets_in_magazine};
    assign moved   = (status.bullets_left < missing) ? status.bullets_left : missing;

    // --------------------
    // next state
    // --------------------
    always_comb begin
        status_nxt             = status;
        delay_nxt              = delay_cnt;
        status_nxt.duck_killed = 1'b0;

        case (status.state)
            wait_for_start: begin
                status_nxt = status_init;
                delay_nxt  = '0;
                if (game_enable) begin
                    status_nxt.state = delay;
                    delay_nxt        = countdown_load;
                end
            end

            // start countdown or pause after a kill
            delay: begin
                if (take_reload) begin
                    status_nxt.state = reloading;
                end else if (delay_cnt == '0) begin
                    status_nxt.state = hunting;
                end else begin
                    delay_nxt = delay_cnt - 1'b1;
                end
            end

            hunting: begin
                if (take_reload) begin
                    status_nxt.state = reloading;
                end else if (take_shot) begin
                    if (status.bullets_in_magazine != 3'd0) begin
                        status_nxt.bullets_in_magazine = status.bullets_in_magazine - 3'd1;
                        if (hit) begin
                            status_nxt.score       = status.score + 7'd1;
                            status_nxt.duck_killed = 1'b1;
                            status_nxt.state       = delay;
                            delay_nxt              = death_load;
                        end
                    end else begin
                        status_nxt.show_reload_char = 1'b1;
                    end
                end
            end

            reloading: begin
                status_nxt.state = delay;
            end

            default: begin
                status_nxt = status_init;
                delay_nxt  = '0;
            end
        endcase

        // rounds move on the way into reloading
        if (status_nxt.state == reloading && status.state != reloading) begin
            status_nxt.bullets_in_magazine = status.bullets_in_magazine + moved[2:0];
            status_nxt.bullets_left        = status.bullets_left - moved;
            status_nxt.show_reload_char    = 1'b0;
        end

        // disable drops straight back to the start screen
        if (!game_enable) begin
            status_nxt = status_init;
            delay_nxt  = '0;
        end

        status_nxt.hunt_start = (status_nxt.state == hunting);
    end

    // --------------------
    // registers
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            status    <= status_init;
            delay_cnt <= '0;
        end else begin
            status    <= status_nxt;
            delay_cnt <= delay_nxt;
        end
    end

endmodule

`default_nettype wire

// File: logic/duck_hunt_top.sv
`timescale 1ns/1ps
`default_nettype none

module duck_hunt_top
    import duck_pkg::*;
(
    input  wire          clk,
    input  wire          rst,
    input  wire duck_pos_t mouse_pos,
    input  wire          left_mouse,
    input  wire          right_mouse,
    input  wire          game_enable,
    output game_status_t status,
    output duck_pos_t    duck
);

    logic        push;
    shot_event_t push_event;
    logic        pop;
    logic        empty;
    shot_event_t head;

    // --------------------
    // input side
    // --------------------
    shot_capture shot_capture_inst (
        .clk         (clk),
        .rst         (rst),
        .left_mouse  (left_mouse),
        .right_mouse (right_mouse),
        .mouse_pos   (mouse_pos),
        .push        (push),
        .push_event  (push_event)
    );

    // full only matters for deeper queues
    shot_fifo shot_fifo_inst (
        .clk        (clk),
        .rst        (rst),
        .push       (push),
        .push_event (push_event),
        .pop        (pop),
        .head       (head),
        .empty      (empty),
        .full       ()
    );

    // --------------------
    // game side
    // --------------------
    duck_flight duck_flight_inst (
        .clk         (clk),
        .rst         (rst),
        .hunt_start  (status.hunt_start),
        .duck_killed (status.duck_killed),
        .duck        (duck)
    );

    duck_game_logic duck_game_logic_inst (
        .clk         (clk),
        .rst         (rst),
        .game_enable (game_enable),
        .head        (head),
        .empty       (empty),
        .pop         (pop),
        .duck        (duck),
        .status      (status)
    );

endmodule

`default_nettype wire

// File: logic/duck_pkg.sv
`default_nettype none

`include "duck_defs.svh"

package duck_pkg;

    // one mouse action, cursor captured on the button edge
    typedef struct packed {
        logic               is_reload;
        logic [`COORD_W-1:0] xpos;
        logic [`COORD_W-1:0] ypos;
    } shot_event_t;

    // top-left corner of the duck sprite
    typedef struct packed {
        logic [`COORD_W-1:0] xpos;
        logic [`COORD_W-1:0] ypos;
    } duck_pos_t;

    typedef enum logic [1:0] {
        wait_for_start = 2'b00,
        delay          = 2'b01,
        hunting        = 2'b10,
        reloading      = 2'b11
    } game_state_t;

    // everything the display side needs
    typedef struct packed {
        logic [2:0]  bullets_in_magazine;
        logic [6:0]  bullets_left;
        logic [6:0]  score;
        logic        hunt_start;
        logic        show_reload_char;
        // single-cycle pulse on a hit
        logic        duck_killed;
        game_state_t state;
    } game_status_t;

endpackage

`default_nettype wire

// File: logic/shot_capture.sv
`timescale 1ns/1ps
`default_nettype none

module shot_capture
    import duck_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         left_mouse,
    input  wire         right_mouse,
    input  wire duck_pos_t mouse_pos,
    output logic        push,
    output shot_event_t push_event
);

    logic left_prev;
    logic right_prev;
    logic left_rise;
    logic right_rise;

    // --------------------
    // edge detect
    // --------------------
    assign left_rise  = left_mouse & ~left_prev;
    assign right_rise = right_mouse & ~right_prev;

    always_ff @(posedge clk) begin
        if (rst) begin
            left_prev  <= 1'b0;
            right_prev <= 1'b0;
            push       <= 1'b0;
        end else begin
            left_prev  <= left_mouse;
            right_prev <= right_mouse;
            push       <= left_rise | right_rise;
        end
    end

    // --------------------
    // event payload
    // --------------------
    // reload wins when both buttons rise together
    always_ff @(posedge clk) begin
        if (left_rise || right_rise) begin
            push_event.is_reload <= right_rise;
            push_event.xpos      <= mouse_pos.xpos;
            push_event.ypos      <= mouse_pos.ypos;
        end
    end

endmodule

`default_nettype wire

// File: logic/shot_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "duck_defs.svh"

module shot_fifo
    import duck_pkg::*;
(
    input  wire         clk,
    input  wire         rst,
    input  wire         push,
    input  wire shot_event_t push_event,
    input  wire         pop,
    output shot_event_t head,
    output logic        empty,
    output logic        full
);

    localparam int depth = `SHOT_FIFO_DEPTH;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
    localparam logic [ptr_w-1:0] last_slot = ptr_w'(depth - 1);
    localparam logic [ptr_w:0] full_count = (ptr_w + 1)'(depth);

    shot_event_t      mem [depth];
    logic [ptr_w-1:0] wr_ptr;
    logic [ptr_w-1:0] rd_ptr;
    logic [ptr_w:0]   count;
    logic             do_push;
    logic             do_pop;

    // wrap for depths that are not a power of two
    function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
        return (ptr == last_slot) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == full_count);

    // overflowing pushes and underflowing pops are dropped
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign head = mem[rd_ptr];

    // --------------------
    // storage
    // --------------------
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_event;
        end
    end

    // --------------------
    // pointers and occupancy
    // --------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire
